// File: common/ir_defs.svh
`ifndef IR_DEFS_SVH
`define IR_DEFS_SVH

// System clock cycles per audio sample step.
`define STEP_DIVIDE 8

// Final value of the pulse length counter. The pulse lasts two steps more
// than this count, so 143 gives a pulse of 145 steps.
`define IMPULSE_LAST_COUNT 143

// Pulse amplitude as a signed 16-bit word (-8193).
`define IMPULSE_LEVEL 16'shDFFF

// Delay of the single echo tap, in audio steps.
`define ECHO_DELAY 32

// Number of samples recorded per measurement.
`define CAPTURE_LEN 512

`endif

// File: common/ir_pkg.sv
// Types shared by the impulse response RTL and its testbench.
package ir_pkg;

  // One audio sample. Every audio path in the design carries this word,
  // from the generator drive through the echo model into the capture buffer.
  typedef logic signed [15:0] sample_t;

  // Index into the capture buffer, wide enough for 512 entries.
  typedef logic [8:0] capture_addr_t;

endpackage

// File: hw/audio_step_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ir_defs.svh"

// Divides the system clock down to the audio sample rate.
module audio_step_timer (
  input  logic clk_in,
  input  logic rst_in,
  output logic step   // High for one cycle in every STEP_DIVIDE cycles.
);

  localparam int COUNT_W = $clog2(`STEP_DIVIDE);
  localparam logic [COUNT_W-1:0] LAST_COUNT = COUNT_W'(`STEP_DIVIDE - 1);

  logic [COUNT_W-1:0] count;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      count <= '0;
      step  <= 1'b0;
    end else if (count == LAST_COUNT) begin
      count <= '0;
      step  <= 1'b1;  // The first strobe lands STEP_DIVIDE cycles after reset.
    end else begin
      count <= count + 1'b1;
      step  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/impulse_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "ir_defs.svh"

// Sends one rectangular impulse per trigger, aligned to the audio step.
// The trigger is only looked at while the generator is waiting.
module impulse_generator (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            step_in,
  input  logic            impulse_in,   // Trigger level.
  output logic            impulse_out,  // One cycle at the last step of the pulse.
  output ir_pkg::sample_t amp_out       // Drive toward the speaker.
);

  typedef enum logic [1:0] {
    WAITING,
    WILL_SEND,
    SENDING,
    SENT
  } gen_state_t;

  localparam logic [7:0] LAST_COUNT = 8'(`IMPULSE_LAST_COUNT);

  gen_state_t state;
  logic [7:0] length_count;  // Steps spent at the pulse level so far.

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state        <= WAITING;
      length_count <= '0;
      impulse_out  <= 1'b0;
      amp_out      <= '0;
    end else begin
      case (state)
        WAITING: begin
          amp_out <= '0;
          if (impulse_in) begin
            state <= WILL_SEND;
          end
        end

        WILL_SEND: begin
          // The pulse starts on a step boundary, never mid-step.
          if (step_in) begin
            amp_out      <= `IMPULSE_LEVEL;
            length_count <= '0;
            state        <= SENDING;
          end
        end

        SENDING: begin
          if (step_in) begin
            if (length_count == LAST_COUNT) begin
              impulse_out <= 1'b1;  // Marks the 145th step edge.
              state       <= SENT;
            end else begin
              length_count <= length_count + 1'b1;
            end
          end
        end

        SENT: begin
          impulse_out <= 1'b0;
          // The level is held for one more step, then released.
          if (step_in) begin
            amp_out <= '0;
            state   <= WAITING;
          end
        end

        default: begin
          impulse_out <= 1'b0;
          amp_out     <= '0;
          state       <= WAITING;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/echo_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "ir_defs.svh"

// Model of the acoustic path as a feedback comb filter.
//   y[n] = x[n] + y[n - ECHO_DELAY] / 2, with the halving rounded toward zero.
// The last ECHO_DELAY outputs sit in a circular delay line.
module echo_channel (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            step,
  input  ir_pkg::sample_t sample_in,
  output ir_pkg::sample_t sample_out
);

  localparam int PTR_W = $clog2(`ECHO_DELAY);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`ECHO_DELAY - 1);

  ir_pkg::sample_t delay_line [`ECHO_DELAY];

  logic [PTR_W-1:0] ptr;          // Slot of the oldest output, overwritten each step.
  logic             line_primed;  // Set once the pointer has swept every slot.

  ir_pkg::sample_t oldest;
  ir_pkg::sample_t echo_half;
  ir_pkg::sample_t next_out;

  // Slots not yet written since reset hold stale data, so they read as silence
  // until the pointer has gone once around the line.
  always_comb begin
    oldest = line_primed ? delay_line[ptr] : '0;
    if (oldest < 0) begin
      echo_half = (oldest + 16'sd1) >>> 1;  // Keeps negative tails from sticking at -1.
    end else begin
      echo_half = oldest >>> 1;
    end
    next_out = sample_in + echo_half;  // Headroom is ample for the pulse level used.
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ptr         <= '0;
      line_primed <= 1'b0;
      sample_out  <= '0;
    end else if (step) begin
      sample_out <= next_out;
      if (ptr == LAST_PTR) begin
        ptr         <= '0;
        line_primed <= 1'b1;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // The new output replaces the one it just consumed.
  always_ff @(posedge clk_in) begin
    if (step && !rst_in) begin
      delay_line[ptr] <= next_out;
    end
  end

endmodule

`default_nettype wire

// File: capture/response_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "ir_defs.svh"

// Records a fixed window of the channel output, one sample per audio step.
// The buffer can be read at any time through a registered port.
module response_capture (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  step,
  input  logic                  arm,        // Trigger level, seen only while idle.
  input  ir_pkg::sample_t       sample_in,
  input  ir_pkg::capture_addr_t rd_addr,
  output ir_pkg::sample_t       rd_data,
  output logic                  busy,
  output logic                  done        // Held until the next accepted trigger.
);

  typedef enum logic {
    IDLE,
    RECORDING
  } cap_state_t;

  localparam ir_pkg::capture_addr_t LAST_ADDR = ir_pkg::capture_addr_t'(`CAPTURE_LEN - 1);

  ir_pkg::sample_t buffer [`CAPTURE_LEN];

  cap_state_t            state;
  ir_pkg::capture_addr_t wr_addr;
  logic                  wr_en;

  assign busy  = (state == RECORDING);
  assign wr_en = busy && step;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state   <= IDLE;
      wr_addr <= '0;
      done    <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (arm) begin
            state   <= RECORDING;
            wr_addr <= '0;
            done    <= 1'b0;  // A new window invalidates the old one.
          end
        end

        RECORDING: begin
          if (step) begin
            if (wr_addr == LAST_ADDR) begin
              state <= IDLE;
              done  <= 1'b1;
            end else begin
              wr_addr <= wr_addr + 1'b1;
            end
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Sample buffer write port.
  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      buffer[wr_addr] <= sample_in;
    end
  end

  // Read port with one cycle of latency, independent of recording.
  always_ff @(posedge clk_in) begin
    rd_data <= buffer[rd_addr];
  end

endmodule

`default_nettype wire

// File: hw/ir_measure_top.sv
`timescale 1ns/1ps
`default_nettype none

// Impulse response measurement subsystem.
// A trigger fires one impulse through the echo model and records the response.
module ir_measure_top (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  trigger,       // Starts a measurement when both blocks are idle.
  input  ir_pkg::capture_addr_t rd_addr,
  output ir_pkg::sample_t       amp,           // Drive signal toward the speaker.
  output logic                  impulse_done,
  output logic                  capture_busy,
  output logic                  capture_done,
  output ir_pkg::sample_t       rd_data
);

  logic            step;        // Audio sample strobe shared by all stages.
  ir_pkg::sample_t channel_out;

  audio_step_timer u_step_timer (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .step   (step)
  );

  impulse_generator u_impulse_gen (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .step_in     (step),
    .impulse_in  (trigger),
    .impulse_out (impulse_done),
    .amp_out     (amp)
  );

  // The pulse goes straight into the acoustic path model.
  echo_channel u_echo_channel (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .step       (step),
    .sample_in  (amp),
    .sample_out (channel_out)
  );

  // Arms on the same trigger as the generator, so both start on one step.
  response_capture u_capture (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .step      (step),
    .arm       (trigger),
    .sample_in (channel_out),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .busy      (capture_busy),
    .done      (capture_done)
  );

endmodule

`default_nettype wire

// File: verif/ir_measure_tb.sv
`timescale 1ns/1ps

`include "ir_defs.svh"

module ir_measure_tb;

  localparam int CLK_HALF     = 50;  // 100 ns clock period.
  localparam int RESET_CYCLES = 8;
  localparam int unsigned SEED = 32'h36cc6566;

  // Pulse shape expected at amp. 143 as the last count means 145 steps.
  localparam ir_pkg::sample_t PULSE_LEVEL = -16'sd8193;
  localparam int PULSE_STEPS  = `IMPULSE_LAST_COUNT + 2;
  localparam int PULSE_CYCLES = PULSE_STEPS * `STEP_DIVIDE;
  localparam int DONE_CYCLE   = (PULSE_STEPS - 1) * `STEP_DIVIDE + 1;
  localparam int CAPTURE_TAIL = (`CAPTURE_LEN - 1) * `STEP_DIVIDE;
  localparam int MODEL_LEN    = 2 * `CAPTURE_LEN;

  // Three measurement windows with a 20% margin.
  localparam int MEAS_CYCLES    = (`CAPTURE_LEN + 4) * `STEP_DIVIDE;
  localparam int TIMEOUT_CYCLES = 3 * MEAS_CYCLES * 12 / 10;

  logic                  clk_in;
  logic                  rst_in;
  logic                  trigger;
  ir_pkg::capture_addr_t rd_addr;
  ir_pkg::sample_t       amp;
  logic                  impulse_done;
  logic                  capture_busy;
  logic                  capture_done;
  ir_pkg::sample_t       rd_data;

  ir_pkg::sample_t expected_buf [`CAPTURE_LEN];
  int              comb_y [MODEL_LEN];  // Comb output for a pulse starting at index 0.
  int              quiet_steps;         // Extra steps after a capture until the comb is silent.

  int   cycle_count = 0;
  logic measure_started = 1'b0;
  int   level_cycles = 0;
  int   pulse_count = 0;
  int   done_pulses = 0;
  int   amp_rise_cycle = 0;
  int   busy_rise_cycle = 0;
  logic prev_busy = 1'b0;

  ir_measure_top UUT (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .trigger      (trigger),
    .rd_addr      (rd_addr),
    .amp          (amp),
    .impulse_done (impulse_done),
    .capture_busy (capture_busy),
    .capture_done (capture_done),
    .rd_data      (rd_data)
  );

  initial begin
    clk_in = 1'b0;
    forever #(CLK_HALF) clk_in = ~clk_in;
  end

  always @(posedge clk_in) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic stop_run(input string why);
    $display("Test failed");
    $display("%s", why);
    $fatal(1, "Simulation stopped at the first failing check.");
  endtask

  task automatic flag_mismatch(input string name, input int expected, input int actual);
    stop_run($sformatf("ERROR at %0t: %s expected %0d, got %0d",
                       $time, name, expected, actual));
  endtask

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) @(posedge clk_in);
    stop_run($sformatf("Timeout after %0d clock cycles without finishing the test.",
                       TIMEOUT_CYCLES));
  end

  // Reference model: a 145-sample pulse into y[n] = x[n] + y[n-32]/2.
  // Integer division truncates, which is the rounding toward zero of the channel.
  task automatic build_model();
    int x;
    int echo;
    int last_loud;
    last_loud = -1;
    for (int n = 0; n < MODEL_LEN; n++) begin
      x = (n < PULSE_STEPS) ? int'(PULSE_LEVEL) : 0;
      echo = (n >= `ECHO_DELAY) ? comb_y[n - `ECHO_DELAY] / 2 : 0;
      comb_y[n] = x + echo;
      if (comb_y[n] != 0) begin
        last_loud = n;
      end
    end
    if (last_loud >= MODEL_LEN - `ECHO_DELAY) begin
      stop_run("The comb model did not decay to silence within its length.");
    end
    // Two stage registers put two zeros ahead of the response.
    for (int k = 0; k < `CAPTURE_LEN; k++) begin
      expected_buf[k] = (k < 2) ? 16'sd0 : ir_pkg::sample_t'(comb_y[k - 2]);
    end
    quiet_steps = last_loud + `ECHO_DELAY + 2 - `CAPTURE_LEN;
    if (quiet_steps < 1) begin
      quiet_steps = 1;
    end
  endtask

  // Outputs must stay quiet through reset and until the first trigger.
  always @(negedge clk_in) begin
    if (cycle_count >= 1 && !measure_started) begin
      assert (amp == 16'sd0) else flag_mismatch("amp", 0, int'(amp));
      assert (!impulse_done) else flag_mismatch("impulse_done", 0, int'(impulse_done));
      assert (!capture_busy) else flag_mismatch("capture_busy", 0, int'(capture_busy));
      assert (!capture_done) else flag_mismatch("capture_done", 0, int'(capture_done));
    end
  end

  // Tracks pulse length, impulse_done position and capture window length.
  always @(negedge clk_in) begin
    if (!rst_in) begin
      if (capture_busy && !prev_busy) begin
        busy_rise_cycle = cycle_count;
        assert (!capture_done) else flag_mismatch("capture_done", 0, int'(capture_done));
      end
      if (!capture_busy && prev_busy) begin
        assert (cycle_count - amp_rise_cycle == CAPTURE_TAIL)
          else flag_mismatch("capture_busy cycles after pulse start", CAPTURE_TAIL,
                             cycle_count - amp_rise_cycle);
      end
      prev_busy = capture_busy;

      assert (amp == 16'sd0 || amp == PULSE_LEVEL)
        else flag_mismatch("amp", int'(PULSE_LEVEL), int'(amp));
      if (amp == PULSE_LEVEL) begin
        if (level_cycles == 0) begin
          amp_rise_cycle = cycle_count;
          assert (cycle_count - busy_rise_cycle >= 1 &&
                  cycle_count - busy_rise_cycle <= `STEP_DIVIDE)
            else stop_run("The pulse did not start at the first step after the trigger.");
        end
        level_cycles++;
      end else if (level_cycles != 0) begin
        assert (level_cycles == PULSE_CYCLES)
          else flag_mismatch("amp pulse cycles", PULSE_CYCLES, level_cycles);
        pulse_count++;
        level_cycles = 0;
      end

      if (impulse_done) begin
        done_pulses++;
        assert (level_cycles == DONE_CYCLE)
          else flag_mismatch("impulse_done cycle within pulse", DONE_CYCLE, level_cycles);
      end
    end
  end

  done_one_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
                                   impulse_done |=> !impulse_done)
    else stop_run("impulse_done stayed high for more than one cycle.");

  busy_needs_trigger: assert property (@(posedge clk_in) disable iff (rst_in)
                                       $rose(capture_busy) |-> $past(trigger))
    else stop_run("capture_busy rose without a trigger.");

  done_with_busy_fall: assert property (@(posedge clk_in) disable iff (rst_in)
                                        $fell(capture_busy) |-> capture_done)
    else stop_run("capture_done did not rise when capture_busy fell.");

  done_held: assert property (@(posedge clk_in) disable iff (rst_in)
                              $fell(capture_done) |-> $past(trigger))
    else stop_run("capture_done fell without a new trigger.");

  // One trigger, then random extra trigger pulses while the impulse is on.
  task automatic run_measurement(input int index);
    measure_started = 1'b1;
    @(negedge clk_in);
    trigger = 1'b1;
    @(negedge clk_in);
    trigger = 1'b0;
    assert (capture_busy) else flag_mismatch("capture_busy", 1, int'(capture_busy));
    assert (!capture_done) else flag_mismatch("capture_done", 0, int'(capture_done));
    while (amp == 16'sd0) @(negedge clk_in);
    while (amp != 16'sd0) begin
      trigger = ($urandom_range(7) == 0);
      @(negedge clk_in);
    end
    trigger = 1'b0;
    while (!capture_done) @(negedge clk_in);
    assert (pulse_count == index) else flag_mismatch("impulse count", index, pulse_count);
    assert (done_pulses == index)
      else flag_mismatch("impulse_done pulses", index, done_pulses);
  endtask

  // Reads every entry once in a shuffled order, one read per cycle.
  task automatic read_back_and_check();
    int order [`CAPTURE_LEN];
    int pick;
    int swap;
    for (int i = 0; i < `CAPTURE_LEN; i++) begin
      order[i] = i;
    end
    for (int i = `CAPTURE_LEN - 1; i > 0; i--) begin
      pick = int'($urandom_range(i));
      swap = order[i];
      order[i] = order[pick];
      order[pick] = swap;
    end
    @(negedge clk_in);
    rd_addr = ir_pkg::capture_addr_t'(order[0]);
    for (int i = 0; i < `CAPTURE_LEN; i++) begin
      @(negedge clk_in);
      assert (rd_data == expected_buf[order[i]])
        else flag_mismatch($sformatf("rd_data[%0d]", order[i]),
                           int'(expected_buf[order[i]]), int'(rd_data));
      if (i + 1 < `CAPTURE_LEN) begin
        rd_addr = ir_pkg::capture_addr_t'(order[i + 1]);
      end
    end
  endtask

  // Lets the echo tail die out so the next window starts from silence.
  task automatic wait_for_silence();
    repeat (quiet_steps * `STEP_DIVIDE) @(negedge clk_in);
  endtask

  initial begin
    rst_in = 1'b1;
    trigger = 1'b0;
    rd_addr = '0;
    void'($urandom(SEED));
    build_model();
    repeat (RESET_CYCLES) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
    repeat (4) @(negedge clk_in);

    run_measurement(1);
    read_back_and_check();
    wait_for_silence();
    run_measurement(2);  // Must reproduce the first buffer exactly.
    read_back_and_check();

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: ir_measure_top.f
+incdir+common
common/ir_pkg.sv
hw/audio_step_timer.sv
hw/impulse_generator.sv
hw/echo_channel.sv
capture/response_capture.sv
hw/ir_measure_top.sv
verif/ir_measure_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the impulse response testbench with Verilator and runs it.
# The script exits with the simulator's status, so a failed check fails the script.

cd "$(dirname "$0")" || exit 1

TOP=ir_measure_tb
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f ir_measure_top.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

"./$BUILD_DIR/$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished with status 0"
exit 0
